// ==== sources.f ====
src/dsp_pkg.sv
src/simd_cfg_chain.sv
src/alu_ctrl_decode.sv
src/alu_lane.sv
src/simd_alu.sv
src/dsp_slice.sv
test/tb_dsp_slice.sv
+incdir+test

// ==== src/alu_ctrl_decode.sv ====
// ALU control decoder.
// Turns alumode and opmode into the function class, the z and result
// inversions and the carryout enable used by the lanes.
`default_nettype none

module alu_ctrl_decode import dsp_pkg::*; (
	input  wire logic [3:0] alumode,
	input  wire logic [8:0] opmode,
	output alu_ctrl_t       ctrl
);

	always_comb begin
		ctrl.fn       = fn_arith;
		ctrl.z_inv    = 1'b0;
		ctrl.s_inv    = 1'b0;
		ctrl.carry_en = 1'b0;

		unique case (alumode[3:2])
			2'b00: begin
				unique case (alumode)
					ALUMODE_ADD: begin
						ctrl.carry_en = 1'b1;
					end
					ALUMODE_NZ_ADD: begin
						ctrl.z_inv = 1'b1;
					end
					ALUMODE_NOT_ADD: begin
						ctrl.s_inv = 1'b1;
					end
					ALUMODE_SUB: begin // ~(~z + t) = z - t.
						ctrl.z_inv = 1'b1;
						ctrl.s_inv = 1'b1;
					end
				endcase
			end
			2'b01: begin
				ctrl.fn = fn_xor;
			end
			2'b11: begin
				ctrl.fn = opmode[3] ? fn_or : fn_and;
			end
			default: begin
				// logic class with s_inv set blanks the result
				ctrl.fn    = fn_and;
				ctrl.s_inv = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/alu_lane.sv ====
// One 12-bit ALU lane.
// Reduces w, x, y and z to two vectors with two 3:2 compressor rows, then
// adds them. Each stage exposes its top carry so lanes can be chained.
// In logic modes the lane gives a bitwise function of x and z.
`default_nettype none

module alu_lane import dsp_pkg::*; (
	input  wire logic [LANE_W-1:0] w,
	input  wire logic [LANE_W-1:0] x,
	input  wire logic [LANE_W-1:0] y,
	input  wire logic [LANE_W-1:0] z,
	input  wire alu_ctrl_t         ctrl,
	input  wire logic              cin_a,
	input  wire logic              cin_b,
	input  wire logic              cin_c,
	output logic [LANE_W-1:0]      s,
	output logic                   cout_a,
	output logic                   cout_b,
	output logic                   cout_c
);

	logic [LANE_W-1:0] z_eff;
	logic [LANE_W-1:0] sum1;
	logic [LANE_W-1:0] maj1;
	logic [LANE_W-1:0] c1;
	logic [LANE_W-1:0] sum2;
	logic [LANE_W-1:0] maj2;
	logic [LANE_W-1:0] c2;
	logic [LANE_W-1:0] sum;
	logic [LANE_W-1:0] logic_s;

	// carry-save reduction of w + x + y + z.
	always_comb begin
		z_eff = ctrl.z_inv ? ~z : z;

		sum1 = w ^ x ^ y;
		maj1 = (w & x) | (w & y) | (x & y);
		c1   = {maj1[LANE_W-2:0], cin_a};

		sum2 = sum1 ^ c1 ^ z_eff;
		maj2 = (sum1 & c1) | (sum1 & z_eff) | (c1 & z_eff);
		c2   = {maj2[LANE_W-2:0], cin_b};

		{cout_c, sum} = sum2 + c2 + cin_c;
	end

	assign cout_a = maj1[LANE_W-1]; // shifted out of c1.
	assign cout_b = maj2[LANE_W-1];

	always_comb begin
		unique case (ctrl.fn)
			fn_xor:  logic_s = x ^ z;
			fn_and:  logic_s = x & z;
			fn_or:   logic_s = x | z;
			default: logic_s = '0;
		endcase

		if (ctrl.fn == fn_arith) begin
			s = ctrl.s_inv ? ~sum : sum;
		end else begin
			s = ctrl.s_inv ? '0 : logic_s; // blanked logic result.
		end
	end

endmodule

`default_nettype wire

// ==== src/dsp_pkg.sv ====
// DSP slice shared definitions.
// Lane and word widths, SIMD grouping and alumode encodings, and the
// control and operand bundles passed between the slice blocks.
`default_nettype none

package dsp_pkg;

	localparam int LANE_W    = 12;
	localparam int NUM_LANES = 4;
	localparam int DATA_W    = LANE_W * NUM_LANES;

	// arithmetic alumode codes, alumode[3:2] = 00.
	localparam logic [3:0] ALUMODE_ADD     = 4'b0000;
	localparam logic [3:0] ALUMODE_NZ_ADD  = 4'b0001;
	localparam logic [3:0] ALUMODE_NOT_ADD = 4'b0010;
	localparam logic [3:0] ALUMODE_SUB     = 4'b0011;

	typedef logic [DATA_W-1:0]    dsp_word_t;
	typedef logic [NUM_LANES-1:0] lane_carry_t;

	// code 3 is reserved and groups like one48.
	typedef enum logic [1:0] {
		one48  = 2'd0,
		two24  = 2'd1,
		four12 = 2'd2
	} simd_mode_e;

	typedef enum logic [1:0] {
		fn_arith = 2'd0,
		fn_xor   = 2'd1,
		fn_and   = 2'd2,
		fn_or    = 2'd3
	} alu_fn_e;

	typedef struct packed {
		alu_fn_e fn;
		logic    z_inv;    // invert z before the compressors.
		logic    s_inv;    // invert the adder result.
		logic    carry_en; // carryout valid, plain add only.
	} alu_ctrl_t;

	typedef struct packed {
		dsp_word_t w;
		dsp_word_t x;
		dsp_word_t y;
		dsp_word_t z;
		logic      cin;
	} dsp_operands_t;

endpackage

`default_nettype wire

// ==== src/dsp_slice.sv ====
// DSP slice arithmetic/logic stage.
// Registers operands and control codes, runs the SIMD ALU and registers
// the result, two edges from input to s and carryout. The lane grouping
// comes from a serial configuration chain that daisy-chains slices.
`default_nettype none

module dsp_slice import dsp_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic [3:0] alumode,
	input  wire logic [8:0] opmode,
	input  wire dsp_word_t  w,
	input  wire dsp_word_t  x,
	input  wire dsp_word_t  y,
	input  wire dsp_word_t  z,
	input  wire logic       cin,
	output dsp_word_t       s,
	output lane_carry_t     carryout,
	input  wire logic       cfg_in,
	input  wire logic       cfg_en,
	output logic            cfg_out
);

	dsp_operands_t ops_q;
	logic [3:0]    alumode_q;
	logic [8:0]    opmode_q;
	alu_ctrl_t     ctrl;
	simd_mode_e    mode;
	dsp_word_t     s_d;
	lane_carry_t   carryout_d;

	simd_cfg_chain u_cfg (
		.clk     (clk),
		.rst_n   (rst_n),
		.cfg_in  (cfg_in),
		.cfg_en  (cfg_en),
		.cfg_out (cfg_out),
		.mode    (mode)
	);

	alu_ctrl_decode u_decode (
		.alumode (alumode_q),
		.opmode  (opmode_q),
		.ctrl    (ctrl)
	);

	simd_alu u_alu (
		.ops      (ops_q),
		.ctrl     (ctrl),
		.mode     (mode),
		.s        (s_d),
		.carryout (carryout_d)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ops_q     <= '0;
			alumode_q <= '0;
			opmode_q  <= '0;
			s         <= '0;
			carryout  <= '0;
		end else begin
			ops_q     <= '{w: w, x: x, y: y, z: z, cin: cin};
			alumode_q <= alumode;
			opmode_q  <= opmode;
			s         <= s_d; // second edge.
			carryout  <= carryout_d;
		end
	end

endmodule

`default_nettype wire

// ==== src/simd_alu.sv ====
// SIMD ALU.
// Four lanes whose carry chains are joined or cut according to the SIMD
// grouping. cin feeds the lowest lane only. Each group's top lane
// reports bit n of its exact sum on carryout when carries are enabled.
`default_nettype none

module simd_alu import dsp_pkg::*; (
	input  wire dsp_operands_t ops,
	input  wire alu_ctrl_t     ctrl,
	input  wire simd_mode_e    mode,
	output dsp_word_t          s,
	output lane_carry_t        carryout
);

	lane_carry_t link; // lane k takes carries from lane k-1.
	lane_carry_t top;  // lane k ends a group.
	lane_carry_t ca;
	lane_carry_t cb;
	lane_carry_t cc;
	lane_carry_t in_a;
	lane_carry_t in_b;
	lane_carry_t in_c;

	always_comb begin
		unique case (mode)
			two24:   link = 4'b1010;
			four12:  link = 4'b0000;
			default: link = 4'b1110; // one48 and the reserved code.
		endcase
	end

	assign top = {1'b1, ~link[NUM_LANES-1:1]};

	// carries move up one lane, cut at group boundaries.
	assign in_a = {ca[NUM_LANES-2:0], 1'b0} & link;
	assign in_b = {cb[NUM_LANES-2:0], 1'b0} & link;
	assign in_c = ({cc[NUM_LANES-2:0], 1'b0} & link) | lane_carry_t'(ops.cin);

	for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
		alu_lane u_lane (
			.w      (ops.w[k*LANE_W +: LANE_W]),
			.x      (ops.x[k*LANE_W +: LANE_W]),
			.y      (ops.y[k*LANE_W +: LANE_W]),
			.z      (ops.z[k*LANE_W +: LANE_W]),
			.ctrl   (ctrl),
			.cin_a  (in_a[k]),
			.cin_b  (in_b[k]),
			.cin_c  (in_c[k]),
			.s      (s[k*LANE_W +: LANE_W]),
			.cout_a (ca[k]),
			.cout_b (cb[k]),
			.cout_c (cc[k])
		);
	end

	// the three leaving carries all weigh 2^n, so their parity is bit n.
	assign carryout = (ca ^ cb ^ cc) & top & {NUM_LANES{ctrl.carry_en}};

endmodule

`default_nettype wire

// ==== src/simd_cfg_chain.sv ====
// SIMD configuration chain.
// Two-bit serial shift register loaded through cfg_in while cfg_en is
// high. Its contents give the lane grouping and feed the next slice.
`default_nettype none

module simd_cfg_chain import dsp_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       cfg_in,
	input  wire logic       cfg_en,
	output logic            cfg_out,
	output simd_mode_e      mode
);

	logic [1:0] chain_q;

	// mode bit 1 is shifted in first.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			chain_q <= 2'(one48);
		end else if (cfg_en) begin
			chain_q <= {chain_q[0], cfg_in};
		end
	end

	assign cfg_out = chain_q[1];
	assign mode    = simd_mode_e'(chain_q);

endmodule

`default_nettype wire

// ==== test/tb_model.svh ====
// DSP slice reference model.
// Computes s and carryout per SIMD group with wide arithmetic, from the
// alumode and opmode rules of the slice.
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic int group_width(simd_mode_e mode);
	case (mode)
		two24:   return 24;
		four12:  return 12;
		default: return 48;
	endcase
endfunction

// exact group sum with room for bit n.
function automatic logic [63:0] group_sum(int g, int n, logic [3:0] alumode, dsp_word_t w,
		dsp_word_t x, dsp_word_t y, dsp_word_t z, logic cin);
	logic [63:0] mask;
	logic [63:0] zz;
	logic [63:0] t;
	mask = (64'd1 << n) - 1;
	t = ((64'(w) >> (g * n)) & mask) + ((64'(x) >> (g * n)) & mask)
		+ ((64'(y) >> (g * n)) & mask) + ((g == 0) ? 64'(cin) : 64'd0);
	zz = (64'(z) >> (g * n)) & mask;
	if (alumode == ALUMODE_NZ_ADD || alumode == ALUMODE_SUB)
		zz = ~zz & mask;
	return zz + t;
endfunction

function automatic dsp_word_t model_s(simd_mode_e mode, logic [3:0] alumode,
		logic [8:0] opmode, dsp_word_t w, dsp_word_t x, dsp_word_t y, dsp_word_t z, logic cin);
	int n;
	logic [63:0] sum;
	dsp_word_t r;
	case (alumode[3:2])
		2'b01: return x ^ z;
		2'b11: return opmode[3] ? (x | z) : (x & z);
		2'b10: return '0;
		default: r = '0;
	endcase
	n = group_width(mode);
	for (int g = 0; g < DATA_W / n; g++) begin
		sum = group_sum(g, n, alumode, w, x, y, z, cin);
		if (alumode == ALUMODE_NOT_ADD || alumode == ALUMODE_SUB)
			sum = ~sum;
		r = r | dsp_word_t'((sum & ((64'd1 << n) - 1)) << (g * n));
	end
	return r;
endfunction

function automatic lane_carry_t model_carry(simd_mode_e mode, logic [3:0] alumode,
		dsp_word_t w, dsp_word_t x, dsp_word_t y, dsp_word_t z, logic cin);
	int n;
	logic [63:0] sum;
	lane_carry_t c;
	c = '0;
	if (alumode != ALUMODE_ADD)
		return c;
	n = group_width(mode);
	for (int g = 0; g < DATA_W / n; g++) begin
		sum = group_sum(g, n, alumode, w, x, y, z, cin);
		c[(g + 1) * n / LANE_W - 1] = sum[n]; // group-top lane.
	end
	return c;
endfunction

`endif

// ==== test/tb_dsp_slice.sv ====
// DSP slice testbench.
// Loads the SIMD mode through the configuration chain, applies a table of
// directed and random vectors back to back and checks s and carryout two
// edges later against hand values or the reference model.
`default_nettype none

module tb_dsp_slice import dsp_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	`include "tb_model.svh"

	typedef struct packed {
		simd_mode_e  mode;
		logic [3:0]  alumode;
		logic [8:0]  opmode;
		dsp_word_t   w;
		dsp_word_t   x;
		dsp_word_t   y;
		dsp_word_t   z;
		logic        cin;
		logic        rnd;
		dsp_word_t   exp_s;
		lane_carry_t exp_c;
	} row_t;

	typedef struct packed {
		logic        valid;
		dsp_word_t   s;
		lane_carry_t c;
	} exp_t;

	logic clk = 1'b0;
	logic rst_n;
	logic [3:0] alumode;
	logic [8:0] opmode;
	dsp_word_t w, x, y, z;
	logic cin;
	dsp_word_t s;
	lane_carry_t carryout;
	logic cfg_in, cfg_en, cfg_out;

	row_t rows[$];
	exp_t exp_q[$];
	simd_mode_e cur_mode;

	dsp_slice u_dut (
		.clk(clk), .rst_n(rst_n), .alumode(alumode), .opmode(opmode),
		.w(w), .x(x), .y(y), .z(z), .cin(cin), .s(s), .carryout(carryout),
		.cfg_in(cfg_in), .cfg_en(cfg_en), .cfg_out(cfg_out)
	);

	always #2 clk = ~clk;

	task automatic check_word(string name, dsp_word_t got, dsp_word_t exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s: got %h expected %h", $time, name, got, exp);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_carry(string name, lane_carry_t got, lane_carry_t exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s: got %b expected %b", $time, name, got, exp);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_mode(string name, simd_mode_e got, simd_mode_e exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s: got %0d expected %0d", $time, name, got, exp);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s: got %b expected %b", $time, name, got, exp);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	function automatic row_t mk(simd_mode_e m, logic [3:0] am, logic [8:0] om, dsp_word_t wv,
			dsp_word_t xv, dsp_word_t yv, dsp_word_t zv, logic c, dsp_word_t es, lane_carry_t ec);
		return '{mode: m, alumode: am, opmode: om, w: wv, x: xv, y: yv, z: zv, cin: c,
			rnd: 1'b0, exp_s: es, exp_c: ec};
	endfunction

	function automatic row_t mk_rand(simd_mode_e m, logic [3:0] am, logic [8:0] om);
		row_t r;
		r = '0;
		r.mode = m;
		r.alumode = am;
		r.opmode = om;
		r.rnd = 1'b1;
		return r;
	endfunction

	// drive one vector and check the one that left the pipe.
	task automatic step(logic valid, row_t r);
		exp_t e;
		exp_t old;
		@(posedge clk);
		alumode <= r.alumode;
		opmode <= r.opmode;
		w <= r.w;
		x <= r.x;
		y <= r.y;
		z <= r.z;
		cin <= r.cin;
		e = '{valid: valid, s: r.exp_s, c: r.exp_c};
		exp_q.push_back(e);
		@(negedge clk);
		if (exp_q.size() > 2) begin
			old = exp_q.pop_front();
			if (old.valid) begin
				check_word("s", s, old.s);
				check_carry("carryout", carryout, old.c);
			end
		end
	endtask

	task automatic load_mode(simd_mode_e m);
		logic [1:0] bits;
		logic [1:0] old_bits;
		row_t idle;
		bits = 2'(m);
		old_bits = 2'(cur_mode);
		idle = '0;
		step(1'b0, idle); // drain the pipe.
		step(1'b0, idle);
		@(posedge clk);
		cfg_en <= 1'b1;
		cfg_in <= bits[1];
		@(posedge clk);
		cfg_in <= bits[0];
		@(negedge clk);
		check_bit("cfg_out", cfg_out, old_bits[0]); // old bit 0 moved up.
		@(posedge clk);
		cfg_en <= 1'b0;
		@(negedge clk);
		check_mode("mode", u_dut.u_cfg.mode, m);
		check_bit("cfg_out", cfg_out, bits[1]);
		cur_mode = m;
	endtask

	initial begin
		row_t r;
		void'($urandom(19154));
		rst_n <= 1'b0;
		alumode <= '0;
		opmode <= '0;
		{w, x, y, z} <= '0;
		cin <= 1'b0;
		cfg_in <= 1'b0;
		cfg_en <= 1'b0;
		cur_mode = one48;

		rows.push_back(mk(one48, ALUMODE_ADD, 9'h0, 48'd1, 48'd2, 48'd3, 48'd4, 1'b1,
			48'd11, 4'b0));
		rows.push_back(mk(one48, ALUMODE_ADD, 9'h0, '1, '1, '1, '1, 1'b1,
			48'hFFFF_FFFF_FFFD, 4'b1000));
		rows.push_back(mk(one48, ALUMODE_SUB, 9'h0, 48'd30, '0, '0, 48'd100, 1'b0,
			48'd70, 4'b0));
		rows.push_back(mk(one48, ALUMODE_NZ_ADD, 9'h0, 48'd5, '0, '0, '0, 1'b0, 48'd4, 4'b0));
		rows.push_back(mk(one48, ALUMODE_NOT_ADD, 9'h0, 48'd1, '0, '0, 48'd1, 1'b0,
			48'hFFFF_FFFF_FFFD, 4'b0));
		rows.push_back(mk(one48, 4'b0100, 9'h0, '0, 48'hF0F0, '0, 48'hFF00, 1'b0,
			48'h0FF0, 4'b0));
		rows.push_back(mk(one48, 4'b1100, 9'h008, '0, 48'hF0F0, '0, 48'hFF00, 1'b0,
			48'hFFF0, 4'b0));
		rows.push_back(mk(one48, 4'b1100, 9'h000, '0, 48'hF0F0, '0, 48'hFF00, 1'b0,
			48'hF000, 4'b0));
		rows.push_back(mk(one48, 4'b1000, 9'h000, '1, '1, '1, '1, 1'b1, '0, 4'b0));
		for (int i = 0; i < 4; i++)
			rows.push_back(mk_rand(one48, ALUMODE_ADD, 9'h0));
		rows.push_back(mk(two24, ALUMODE_ADD, 9'h0, 48'h000001_000000, '0, '0, '1, 1'b1,
			'0, 4'b1010));
		for (int i = 0; i < 4; i++)
			rows.push_back(mk_rand(two24, 4'(i), 9'h0));
		rows.push_back(mk(four12, ALUMODE_ADD, 9'h0, 48'h001_001_001_001, '0, '0, '1, 1'b1,
			48'h000_000_000_001, 4'b1111));
		rows.push_back(mk(four12, ALUMODE_SUB, 9'h0, 48'h006_001_001_001, '0, '0,
			48'h005_005_005_005, 1'b0, 48'hFFF_004_004_004, 4'b0));
		for (int i = 0; i < 8; i++)
			rows.push_back(mk_rand(four12, 4'(i * 4 + i % 4), 9'(i * 8)));

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_word("s", s, '0);
		check_carry("carryout", carryout, '0);
		check_bit("cfg_out", cfg_out, 1'b0);
		check_mode("mode", u_dut.u_cfg.mode, one48);

		foreach (rows[i]) begin
			r = rows[i];
			if (r.mode != cur_mode)
				load_mode(r.mode);
			if (r.rnd) begin
				r.w = dsp_word_t'({$urandom(), $urandom()});
				r.x = dsp_word_t'({$urandom(), $urandom()});
				r.y = dsp_word_t'({$urandom(), $urandom()});
				r.z = dsp_word_t'({$urandom(), $urandom()});
				r.cin = 1'($urandom());
				r.exp_s = model_s(r.mode, r.alumode, r.opmode, r.w, r.x, r.y, r.z, r.cin);
				r.exp_c = model_carry(r.mode, r.alumode, r.w, r.x, r.y, r.z, r.cin);
			end
			step(1'b1, r);
		end
		r = '0;
		step(1'b0, r);
		step(1'b0, r);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
